// ==== hw/exe_pkg.sv ====
package exe_pkg;

    localparam int data_w = 32;

    typedef enum logic [5:0] {
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_mult,
        op_multu,
        op_div,
        op_divu,
        op_mfhi,
        op_mflo,
        op_mthi,
        op_mtlo,
        op_lw,
        op_lh,
        op_lb,
        op_sw,
        op_sh,
        op_sb,
        op_swl,
        op_swr
    } exe_op_e;

    typedef enum logic [1:0] {
        src_reg,
        src_simm,
        src_uimm
    } src2_sel_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_fn_e;

    typedef enum logic [2:0] {
        cls_alu,
        cls_muldiv,
        cls_mfhilo,
        cls_load,
        cls_store
    } op_class_e;

    // MIPS cause register codes
    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exc_e;

    typedef struct packed {
        exe_op_e             op;
        logic                src1_is_sa;
        src2_sel_e           src2;
        logic [4:0]          dest;
        logic [15:0]         imm;
        logic [data_w-1:0]   rs_value;
        logic [data_w-1:0]   rt_value;
    } exe_inst_t;

    typedef struct packed {
        exe_op_e             op;
        op_class_e           cls;
        alu_fn_e             fn;
        logic                chk_ov;
        logic                gr_we;
        logic [4:0]          dest;
        logic [data_w-1:0]   src1;
        logic [data_w-1:0]   src2;
        logic [data_w-1:0]   rt_value;
    } exe_ctrl_t;

    typedef struct packed {
        logic                gr_we;
        logic [4:0]          dest;
        logic [data_w-1:0]   value;
        logic                mem_re;
        logic                mem_we;
        logic [1:0]          mem_size;
        logic [data_w-1:0]   mem_addr;
        logic [data_w-1:0]   mem_wdata;
        logic [3:0]          mem_wstrb;
        logic                ex;
        exc_e                excode;
    } exe_result_t;

endpackage

// ==== hw/exe_decode.sv ====
`timescale 1ns/10ps

module exe_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  exe_pkg::exe_inst_t  in_inst,
    input  logic                out_ready,
    input  logic                done,
    output logic                in_ready,
    output logic                out_valid,
    output logic                busy,
    output logic                start,
    output logic                fire,
    output exe_pkg::exe_ctrl_t  ctrl
);

    exe_pkg::exe_inst_t inst_r;
    logic               ready_go;
    logic               is_div;

    assign is_div   = (inst_r.op == exe_pkg::op_div) || (inst_r.op == exe_pkg::op_divu);
    assign ready_go = is_div ? done : 1'b1;

    assign in_ready  = !busy || (ready_go && out_ready);
    assign out_valid = busy && ready_go;
    assign fire      = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            if (in_ready) begin
                busy <= in_valid;
            end
            start <= in_valid && in_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            inst_r <= in_inst;
        end
    end

    always_comb begin
        ctrl          = '0;
        ctrl.op       = inst_r.op;
        ctrl.cls      = exe_pkg::cls_alu;
        ctrl.fn       = exe_pkg::alu_add;
        ctrl.chk_ov   = 1'b0;
        ctrl.gr_we    = 1'b1;
        ctrl.dest     = inst_r.dest;
        ctrl.rt_value = inst_r.rt_value;

        // operands
        ctrl.src1 = inst_r.src1_is_sa ? {27'd0, inst_r.imm[10:6]} : inst_r.rs_value;
        case (inst_r.src2)
            exe_pkg::src_simm: ctrl.src2 = {{16{inst_r.imm[15]}}, inst_r.imm};
            exe_pkg::src_uimm: ctrl.src2 = {16'd0, inst_r.imm};
            default:           ctrl.src2 = inst_r.rt_value;
        endcase

        case (inst_r.op)
            exe_pkg::op_add:   ctrl.chk_ov = 1'b1;
            exe_pkg::op_addu:  ctrl.fn = exe_pkg::alu_add;
            exe_pkg::op_sub: begin
                ctrl.fn     = exe_pkg::alu_sub;
                ctrl.chk_ov = 1'b1;
            end
            exe_pkg::op_subu:  ctrl.fn = exe_pkg::alu_sub;
            exe_pkg::op_slt:   ctrl.fn = exe_pkg::alu_slt;
            exe_pkg::op_sltu:  ctrl.fn = exe_pkg::alu_sltu;
            exe_pkg::op_and:   ctrl.fn = exe_pkg::alu_and;
            exe_pkg::op_or:    ctrl.fn = exe_pkg::alu_or;
            exe_pkg::op_xor:   ctrl.fn = exe_pkg::alu_xor;
            exe_pkg::op_nor:   ctrl.fn = exe_pkg::alu_nor;
            exe_pkg::op_sll:   ctrl.fn = exe_pkg::alu_sll;
            exe_pkg::op_srl:   ctrl.fn = exe_pkg::alu_srl;
            exe_pkg::op_sra:   ctrl.fn = exe_pkg::alu_sra;
            exe_pkg::op_lui:   ctrl.fn = exe_pkg::alu_lui;
            exe_pkg::op_mult, exe_pkg::op_multu, exe_pkg::op_div, exe_pkg::op_divu,
            exe_pkg::op_mthi, exe_pkg::op_mtlo: begin
                ctrl.cls   = exe_pkg::cls_muldiv;
                ctrl.gr_we = 1'b0;
            end
            exe_pkg::op_mfhi, exe_pkg::op_mflo: ctrl.cls = exe_pkg::cls_mfhilo;
            exe_pkg::op_lw, exe_pkg::op_lh, exe_pkg::op_lb: ctrl.cls = exe_pkg::cls_load;
            exe_pkg::op_sw, exe_pkg::op_sh, exe_pkg::op_sb, exe_pkg::op_swl,
            exe_pkg::op_swr: begin
                ctrl.cls   = exe_pkg::cls_store;
                ctrl.gr_we = 1'b0;
            end
            default: ctrl.gr_we = 1'b0;
        endcase
    end

endmodule

// ==== hw/exe_alu.sv ====
`timescale 1ns/10ps

module exe_alu (
    input  exe_pkg::alu_fn_e               fn,
    input  logic [exe_pkg::data_w-1:0]     src1,
    input  logic [exe_pkg::data_w-1:0]     src2,
    output logic [exe_pkg::data_w-1:0]     value,
    output logic                           overflow
);

    logic [exe_pkg::data_w-1:0] sum;
    logic [exe_pkg::data_w-1:0] diff;
    logic [4:0]                 sa;
    logic                       add_ov;
    logic                       sub_ov;

    assign sum  = src1 + src2;
    assign diff = src1 - src2;
    assign sa   = src1[4:0];

    // signed overflow: result sign differs from what the operands allow
    assign add_ov = (src1[31] == src2[31]) && (sum[31] != src1[31]);
    assign sub_ov = (src1[31] != src2[31]) && (diff[31] != src1[31]);

    always_comb begin
        case (fn)
            exe_pkg::alu_add:  value = sum;
            exe_pkg::alu_sub:  value = diff;
            exe_pkg::alu_slt:  value = {31'd0, $signed(src1) < $signed(src2)};
            exe_pkg::alu_sltu: value = {31'd0, src1 < src2};
            exe_pkg::alu_and:  value = src1 & src2;
            exe_pkg::alu_or:   value = src1 | src2;
            exe_pkg::alu_xor:  value = src1 ^ src2;
            exe_pkg::alu_nor:  value = ~(src1 | src2);
            exe_pkg::alu_sll:  value = src2 << sa;
            exe_pkg::alu_srl:  value = src2 >> sa;
            exe_pkg::alu_sra:  value = $unsigned($signed(src2) >>> sa);
            exe_pkg::alu_lui:  value = {src2[15:0], 16'd0};
            default:           value = sum;
        endcase
    end

    always_comb begin
        case (fn)
            exe_pkg::alu_add: overflow = add_ov;
            exe_pkg::alu_sub: overflow = sub_ov;
            default:          overflow = 1'b0;
        endcase
    end

endmodule

// ==== hw/exe_muldiv.sv ====
`timescale 1ns/10ps

module exe_muldiv #(
    parameter int div_step_bits = 1
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic                           fire,
    input  logic                           busy,
    input  exe_pkg::exe_ctrl_t             ctrl,
    input  logic                           no_write,
    output logic                           done,
    output logic [exe_pkg::data_w-1:0]     hi,
    output logic [exe_pkg::data_w-1:0]     lo
);

    localparam int steps = exe_pkg::data_w / div_step_bits;
    localparam int cnt_w = $clog2(steps + 1);

    logic signed [63:0]          prod_s;
    logic [63:0]                 prod_u;
    logic                        is_div;
    logic                        is_signed;
    logic [cnt_w-1:0]            cnt_r;
    logic                        div_done_r;
    logic [32:0]                 rem_r;
    logic [31:0]                 quo_r;
    logic [31:0]                 dvs_r;
    logic                        neg_q_r;
    logic                        neg_r_r;
    logic [32:0]                 nxt_rem;
    logic [31:0]                 nxt_quo;
    logic [31:0]                 quotient;
    logic [31:0]                 remainder;

    assign prod_s = $signed(ctrl.src1) * $signed(ctrl.src2);
    assign prod_u = {32'd0, ctrl.src1} * {32'd0, ctrl.src2};

    assign is_div    = (ctrl.op == exe_pkg::op_div) || (ctrl.op == exe_pkg::op_divu);
    assign is_signed = (ctrl.op == exe_pkg::op_div);

    // restoring steps, div_step_bits quotient bits per cycle
    always_comb begin
        nxt_rem = rem_r;
        nxt_quo = quo_r;
        for (int i = 0; i < div_step_bits; i++) begin
            nxt_rem = {nxt_rem[31:0], nxt_quo[31]};
            nxt_quo = {nxt_quo[30:0], 1'b0};
            if (nxt_rem >= {1'b0, dvs_r}) begin
                nxt_rem    = nxt_rem - {1'b0, dvs_r};
                nxt_quo[0] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_r      <= '0;
            div_done_r <= 1'b0;
        end else if (start && is_div) begin
            cnt_r      <= cnt_w'(steps);
            div_done_r <= 1'b0;
        end else if (cnt_r != '0) begin
            cnt_r <= cnt_r - 1'b1;
            if (cnt_r == cnt_w'(1)) begin
                div_done_r <= 1'b1;
            end
        end else if (fire) begin
            div_done_r <= 1'b0;
        end
    end

    // operands held as magnitudes, signs reapplied at the end
    always_ff @(posedge clk) begin
        if (start && is_div) begin
            rem_r   <= '0;
            quo_r   <= (is_signed && ctrl.src1[31]) ? -ctrl.src1 : ctrl.src1;
            dvs_r   <= (is_signed && ctrl.src2[31]) ? -ctrl.src2 : ctrl.src2;
            neg_q_r <= is_signed && (ctrl.src1[31] ^ ctrl.src2[31]);
            neg_r_r <= is_signed && ctrl.src1[31];
        end else if (cnt_r != '0) begin
            rem_r <= nxt_rem;
            quo_r <= nxt_quo;
        end
    end

    assign quotient  = neg_q_r ? -quo_r : quo_r;
    assign remainder = neg_r_r ? -rem_r[31:0] : rem_r[31:0];

    assign done = busy && (!is_div || div_done_r);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (fire && !no_write) begin
            case (ctrl.op)
                exe_pkg::op_mult: {hi, lo} <= prod_s;
                exe_pkg::op_multu: {hi, lo} <= prod_u;
                exe_pkg::op_div, exe_pkg::op_divu: begin
                    hi <= remainder;
                    lo <= quotient;
                end
                exe_pkg::op_mthi: hi <= ctrl.src1;
                exe_pkg::op_mtlo: lo <= ctrl.src1;
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/exe_result.sv ====
`timescale 1ns/10ps

module exe_result (
    input  exe_pkg::exe_ctrl_t             ctrl,
    input  logic [exe_pkg::data_w-1:0]     alu_value,
    input  logic                           overflow,
    input  logic [exe_pkg::data_w-1:0]     hi,
    input  logic [exe_pkg::data_w-1:0]     lo,
    output exe_pkg::exe_result_t           result,
    output logic                           no_write
);

    logic [1:0]  off;
    logic [31:0] st_data;
    logic [3:0]  st_strb;
    logic [1:0]  size;
    logic        is_load;
    logic        is_store;
    logic        ov_ex;
    logic        load_ex;
    logic        store_ex;
    logic        ex;

    assign off      = alu_value[1:0];
    assign is_load  = (ctrl.cls == exe_pkg::cls_load);
    assign is_store = (ctrl.cls == exe_pkg::cls_store);

    // little-endian lane placement
    always_comb begin
        st_data = '0;
        st_strb = 4'b0000;
        size    = 2'd2;
        case (ctrl.op)
            exe_pkg::op_sb: begin
                st_data = {4{ctrl.rt_value[7:0]}};
                st_strb = 4'b0001 << off;
                size    = 2'd0;
            end
            exe_pkg::op_sh: begin
                st_data = {2{ctrl.rt_value[15:0]}};
                st_strb = off[1] ? 4'b1100 : 4'b0011;
                size    = 2'd1;
            end
            exe_pkg::op_sw: begin
                st_data = ctrl.rt_value;
                st_strb = 4'b1111;
            end
            exe_pkg::op_swl: begin
                st_data = ctrl.rt_value >> {2'd3 - off, 3'b000};
                st_strb = 4'b1111 >> (2'd3 - off);
                size    = (off == 2'd0) ? 2'd0 : (off == 2'd1) ? 2'd1 : 2'd2;
            end
            exe_pkg::op_swr: begin
                st_data = ctrl.rt_value << {off, 3'b000};
                st_strb = 4'b1111 << off;
                size    = !off[1] ? 2'd2 : off[0] ? 2'd0 : 2'd1;
            end
            exe_pkg::op_lh: size = 2'd1;
            exe_pkg::op_lb: size = 2'd0;
            default: ;
        endcase
    end

    assign ov_ex    = ctrl.chk_ov && overflow;
    assign load_ex  = ((ctrl.op == exe_pkg::op_lw) && (off != 2'd0)) ||
                      ((ctrl.op == exe_pkg::op_lh) && off[0]);
    assign store_ex = ((ctrl.op == exe_pkg::op_sw) && (off != 2'd0)) ||
                      ((ctrl.op == exe_pkg::op_sh) && off[0]);
    assign ex       = ov_ex || load_ex || store_ex;
    assign no_write = ex;

    always_comb begin
        result.gr_we = ctrl.gr_we && !ex;
        result.dest  = ctrl.dest;
        case (ctrl.op)
            exe_pkg::op_mfhi: result.value = hi;
            exe_pkg::op_mflo: result.value = lo;
            default:          result.value = alu_value;
        endcase

        result.mem_re    = is_load && !ex;
        result.mem_we    = is_store && !ex;
        result.mem_size  = size;
        // swl addresses the aligned word
        result.mem_addr  = (ctrl.op == exe_pkg::op_swl) ? {alu_value[31:2], 2'b00} : alu_value;
        result.mem_wdata = st_data;
        result.mem_wstrb = result.mem_we ? st_strb : 4'b0000;

        result.ex = ex;
        if (ov_ex) begin
            result.excode = exe_pkg::exc_ov;
        end else if (load_ex) begin
            result.excode = exe_pkg::exc_adel;
        end else if (store_ex) begin
            result.excode = exe_pkg::exc_ades;
        end else begin
            result.excode = exe_pkg::exc_none;
        end
    end

endmodule

// ==== hw/exe_stage.sv ====
`timescale 1ns/10ps

module exe_stage #(
    parameter int div_step_bits = 1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  exe_pkg::exe_inst_t      in_inst,
    output logic                    in_ready,
    output logic                    out_valid,
    output exe_pkg::exe_result_t    out_result,
    input  logic                    out_ready
);

    exe_pkg::exe_ctrl_t          ctrl;
    logic                        busy;
    logic                        start;
    logic                        fire;
    logic                        done;
    logic                        overflow;
    logic                        no_write;
    logic [exe_pkg::data_w-1:0]  alu_value;
    logic [exe_pkg::data_w-1:0]  hi;
    logic [exe_pkg::data_w-1:0]  lo;

    exe_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .out_ready (out_ready),
        .done      (done),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .busy      (busy),
        .start     (start),
        .fire      (fire),
        .ctrl      (ctrl)
    );

    exe_alu u_alu (
        .fn       (ctrl.fn),
        .src1     (ctrl.src1),
        .src2     (ctrl.src2),
        .value    (alu_value),
        .overflow (overflow)
    );

    exe_muldiv #(
        .div_step_bits (div_step_bits)
    ) u_muldiv (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .fire     (fire),
        .busy     (busy),
        .ctrl     (ctrl),
        .no_write (no_write),
        .done     (done),
        .hi       (hi),
        .lo       (lo)
    );

    exe_result u_result (
        .ctrl      (ctrl),
        .alu_value (alu_value),
        .overflow  (overflow),
        .hi        (hi),
        .lo        (lo),
        .result    (out_result),
        .no_write  (no_write)
    );

endmodule

// ==== bench/exe_stage_chk.sv ====
`timescale 1ns/10ps

module exe_stage_chk (
    input logic                  clk,
    input logic                  reset,
    input logic                  busy,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input exe_pkg::exe_result_t  out_result
);

    // stage comes up empty
    reset_empty: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high during or right after reset");

    // stalled result stays put
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("stalled result dropped or changed");

    strobe_needs_we: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_result.mem_we |-> out_result.mem_wstrb == 4'b0000)
        else $error("byte strobes set without a memory write");

    empty_accepts: assert property (@(posedge clk) disable iff (reset)
        !busy |-> in_ready)
        else $error("in_ready low while the stage is empty");

endmodule

// ==== bench/exe_stage_tb.sv ====
`timescale 1ns/10ps

module exe_stage_tb;

    localparam int div_step_bits = 1;
    localparam int div_cycles    = 32 / div_step_bits + 1;
    localparam int n_inst        = 2000;
    localparam int max_cycles    = n_inst * 2 * (div_cycles + 4) + 200;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    exe_pkg::exe_inst_t    in_inst;
    logic                  in_ready;
    logic                  out_valid;
    exe_pkg::exe_result_t  out_result;
    logic                  out_ready;

    exe_pkg::exe_inst_t    inst_q[$];
    int                    acc_q[$];
    exe_pkg::exe_inst_t    cur;
    exe_pkg::exe_result_t  exp_res;
    logic [31:0]           m_hi;
    logic [31:0]           m_lo;
    logic                  taken;
    int                    cyc;
    int                    n_acc;
    int                    n_done;
    int                    reg_err;
    int                    mem_err;
    int                    exc_err;
    int                    other_err;

    exe_stage #(
        .div_step_bits (div_step_bits)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_ready  (out_ready)
    );

    bind exe_stage exe_stage_chk u_chk (
        .clk        (clk),
        .reset      (reset),
        .busy       (busy),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    always #5 clk = ~clk;

    task automatic make_inst(output exe_pkg::exe_inst_t inst);
        inst          = '0;
        inst.op       = exe_pkg::exe_op_e'(6'($urandom % 30));
        inst.src2     = exe_pkg::src_reg;
        inst.dest     = 5'($urandom);
        inst.imm      = 16'($urandom);
        inst.rs_value = $urandom;
        inst.rt_value = $urandom;
        case (inst.op)
            exe_pkg::op_sll, exe_pkg::op_srl, exe_pkg::op_sra:
                inst.src1_is_sa = 1'($urandom);
            exe_pkg::op_add, exe_pkg::op_addu, exe_pkg::op_sub, exe_pkg::op_subu,
            exe_pkg::op_slt, exe_pkg::op_sltu, exe_pkg::op_and, exe_pkg::op_or,
            exe_pkg::op_xor, exe_pkg::op_nor:
                inst.src2 = exe_pkg::src2_sel_e'(2'($urandom % 3));
            exe_pkg::op_lui:
                inst.src2 = ($urandom % 2) ? exe_pkg::src_simm : exe_pkg::src_uimm;
            exe_pkg::op_lw, exe_pkg::op_lh, exe_pkg::op_lb, exe_pkg::op_sw, exe_pkg::op_sh,
            exe_pkg::op_sb, exe_pkg::op_swl, exe_pkg::op_swr:
                inst.src2 = exe_pkg::src_simm;
            exe_pkg::op_div, exe_pkg::op_divu: begin
                // small divisors, zero included, in half of the divides
                if ($urandom % 2) begin
                    inst.rt_value = $urandom % 4;
                end else if (inst.rt_value == 32'd0) begin
                    inst.rt_value = 32'd1;
                end
            end
            default: ;
        endcase
    endtask

    function automatic exe_pkg::exe_result_t expect_result(exe_pkg::exe_inst_t in,
                                                           logic [31:0] cur_hi,
                                                           logic [31:0] cur_lo);
        exe_pkg::exe_result_t r;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          v;
        logic [32:0]          wide;
        logic [1:0]           off;
        logic                 ov;

        a = in.src1_is_sa ? {27'd0, in.imm[10:6]} : in.rs_value;
        case (in.src2)
            exe_pkg::src_simm: b = {{16{in.imm[15]}}, in.imm};
            exe_pkg::src_uimm: b = {16'd0, in.imm};
            default:           b = in.rt_value;
        endcase
        case (in.op)
            exe_pkg::op_sub, exe_pkg::op_subu: v = a - b;
            exe_pkg::op_slt:  v = {31'd0, $signed(a) < $signed(b)};
            exe_pkg::op_sltu: v = {31'd0, a < b};
            exe_pkg::op_and:  v = a & b;
            exe_pkg::op_or:   v = a | b;
            exe_pkg::op_xor:  v = a ^ b;
            exe_pkg::op_nor:  v = ~(a | b);
            exe_pkg::op_sll:  v = b << a[4:0];
            exe_pkg::op_srl:  v = b >> a[4:0];
            exe_pkg::op_sra:  v = 32'($signed(b) >>> a[4:0]);
            exe_pkg::op_lui:  v = {in.imm, 16'd0};
            exe_pkg::op_mfhi: v = cur_hi;
            exe_pkg::op_mflo: v = cur_lo;
            default:          v = a + b;
        endcase

        // 33-bit sign-extended sum disagrees with its own sign bit
        wide = (in.op == exe_pkg::op_sub) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
        ov   = (in.op inside {exe_pkg::op_add, exe_pkg::op_sub}) && (wide[32] != wide[31]);

        off        = v[1:0];
        r          = '0;
        r.dest     = in.dest;
        r.value    = v;
        r.gr_we    = !(in.op inside {exe_pkg::op_mult, exe_pkg::op_multu, exe_pkg::op_div,
                                     exe_pkg::op_divu, exe_pkg::op_mthi, exe_pkg::op_mtlo,
                                     exe_pkg::op_sw, exe_pkg::op_sh, exe_pkg::op_sb,
                                     exe_pkg::op_swl, exe_pkg::op_swr});
        r.mem_re   = in.op inside {exe_pkg::op_lw, exe_pkg::op_lh, exe_pkg::op_lb};
        r.mem_we   = in.op inside {exe_pkg::op_sw, exe_pkg::op_sh, exe_pkg::op_sb,
                                   exe_pkg::op_swl, exe_pkg::op_swr};
        r.mem_size = 2'd2;
        r.mem_addr = v;
        case (in.op)
            exe_pkg::op_lh: r.mem_size = 2'd1;
            exe_pkg::op_lb: r.mem_size = 2'd0;
            exe_pkg::op_sb: begin
                r.mem_size  = 2'd0;
                r.mem_wdata = {4{in.rt_value[7:0]}};
                r.mem_wstrb = 4'b0001 << off;
            end
            exe_pkg::op_sh: begin
                r.mem_size  = 2'd1;
                r.mem_wdata = {2{in.rt_value[15:0]}};
                r.mem_wstrb = off[1] ? 4'b1100 : 4'b0011;
            end
            exe_pkg::op_sw: begin
                r.mem_wdata = in.rt_value;
                r.mem_wstrb = 4'b1111;
            end
            exe_pkg::op_swl: begin
                r.mem_wdata = in.rt_value >> (8 * (3 - off));
                r.mem_wstrb = 4'((1 << (off + 1)) - 1);
                r.mem_addr  = {v[31:2], 2'b00};
            end
            exe_pkg::op_swr: begin
                r.mem_wdata = in.rt_value << (8 * off);
                r.mem_wstrb = 4'b1111 << off;
            end
            default: ;
        endcase
        // partial word stores sized by bytes written
        if (in.op inside {exe_pkg::op_swl, exe_pkg::op_swr}) begin
            case ($countones(r.mem_wstrb))
                1:       r.mem_size = 2'd0;
                2:       r.mem_size = 2'd1;
                default: r.mem_size = 2'd2;
            endcase
        end

        if (ov) begin
            r.excode = exe_pkg::exc_ov;
        end else if ((in.op == exe_pkg::op_lw && off != 2'd0) ||
                     (in.op == exe_pkg::op_lh && off[0])) begin
            r.excode = exe_pkg::exc_adel;
        end else if ((in.op == exe_pkg::op_sw && off != 2'd0) ||
                     (in.op == exe_pkg::op_sh && off[0])) begin
            r.excode = exe_pkg::exc_ades;
        end else begin
            r.excode = exe_pkg::exc_none;
        end
        r.ex = (r.excode != exe_pkg::exc_none);
        if (r.ex) begin
            r.gr_we  = 1'b0;
            r.mem_re = 1'b0;
            r.mem_we = 1'b0;
        end
        if (!r.mem_we) begin
            r.mem_wstrb = 4'b0000;
        end
        return r;
    endfunction

    task automatic update_hilo(exe_pkg::exe_inst_t in);
        logic [63:0] prod;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] rm;
        logic        sgn;

        prod = {{32{in.rs_value[31]}}, in.rs_value} * {{32{in.rt_value[31]}}, in.rt_value};
        sgn  = (in.op == exe_pkg::op_div);
        ma   = (sgn && in.rs_value[31]) ? -in.rs_value : in.rs_value;
        mb   = (sgn && in.rt_value[31]) ? -in.rt_value : in.rt_value;
        if (mb == 32'd0) begin
            q  = '1;
            rm = ma;
        end else begin
            q  = ma / mb;
            rm = ma % mb;
        end
        // truncation toward zero, remainder follows the dividend
        if (sgn && (in.rs_value[31] ^ in.rt_value[31])) begin
            q = -q;
        end
        if (sgn && in.rs_value[31]) begin
            rm = -rm;
        end
        case (in.op)
            exe_pkg::op_mult:  {m_hi, m_lo} = prod;
            exe_pkg::op_multu: {m_hi, m_lo} = {32'd0, in.rs_value} * {32'd0, in.rt_value};
            exe_pkg::op_div, exe_pkg::op_divu: begin
                m_hi = rm;
                m_lo = q;
            end
            exe_pkg::op_mthi:  m_hi = in.rs_value;
            exe_pkg::op_mtlo:  m_lo = in.rs_value;
            default: ;
        endcase
    endtask

    task automatic check_reg(exe_pkg::exe_result_t got, exe_pkg::exe_result_t exp);
        if (got.gr_we !== exp.gr_we || got.dest !== exp.dest ||
            (exp.gr_we && got.value !== exp.value)) begin
            reg_err++;
            $display("MISMATCH %0t: reg write got we=%0b rd=%0d value=%h",
                     $time, got.gr_we, got.dest, got.value);
            $display("  expected we=%0b rd=%0d value=%h",
                     exp.gr_we, exp.dest, exp.value);
        end
    endtask

    task automatic check_mem(exe_pkg::exe_result_t got, exe_pkg::exe_result_t exp, logic mem_op);
        if (got.mem_re !== exp.mem_re || got.mem_we !== exp.mem_we ||
            got.mem_wstrb !== exp.mem_wstrb ||
            (mem_op && (got.mem_size !== exp.mem_size || got.mem_addr !== exp.mem_addr)) ||
            (exp.mem_we && got.mem_wdata !== exp.mem_wdata)) begin
            mem_err++;
            $display("MISMATCH %0t: mem got re=%0b we=%0b size=%0d addr=%h wdata=%h strb=%b",
                     $time, got.mem_re, got.mem_we, got.mem_size, got.mem_addr,
                     got.mem_wdata, got.mem_wstrb);
            $display("  expected re=%0b we=%0b size=%0d addr=%h wdata=%h strb=%b",
                     exp.mem_re, exp.mem_we, exp.mem_size, exp.mem_addr,
                     exp.mem_wdata, exp.mem_wstrb);
        end
    endtask

    task automatic check_exc(exe_pkg::exe_result_t got, exe_pkg::exe_result_t exp);
        if (got.ex !== exp.ex || got.excode !== exp.excode) begin
            exc_err++;
            $display("MISMATCH %0t: exception got ex=%0b code=%0d, expected ex=%0b code=%0d",
                     $time, got.ex, got.excode, exp.ex, exp.excode);
        end
    endtask

    // sample mid-cycle, inputs settled since 1 ns after the edge
    always @(negedge clk) begin
        if (!reset) begin
            cyc = cyc + 1;
            if (out_valid && inst_q.size() == 0) begin
                other_err++;
                $display("error at %0t: result offered with no instruction in the stage",
                         $time);
            end else if (out_valid) begin
                // acceptance is logged half a cycle before its clock edge
                if (inst_q[0].op inside {exe_pkg::op_div, exe_pkg::op_divu} &&
                    cyc - acc_q[0] <= div_cycles) begin
                    other_err++;
                    $display("error at %0t: divide result offered before the divider finished",
                             $time);
                end
                if (out_ready) begin
                    cur = inst_q.pop_front();
                    acc_q.delete(0);
                    exp_res = expect_result(cur, m_hi, m_lo);
                    check_reg(out_result, exp_res);
                    check_mem(out_result, exp_res, exp_res.mem_re || exp_res.mem_we ||
                              cur.op inside {exe_pkg::op_lw, exe_pkg::op_lh, exe_pkg::op_sw,
                                             exe_pkg::op_sh});
                    check_exc(out_result, exp_res);
                    if (!exp_res.ex) begin
                        update_hilo(cur);
                    end
                    n_done++;
                end
            end
            taken = in_valid && in_ready;
            if (taken) begin
                inst_q.push_back(in_inst);
                acc_q.push_back(cyc);
                n_acc++;
            end
            if (cyc >= max_cycles) begin
                $display("timeout: run did not finish within %0d cycles", max_cycles);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(32'hb0df_be6b));
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_inst   = '0;
        out_ready = 1'b0;
        m_hi      = '0;
        m_lo      = '0;
        taken     = 1'b0;
        cyc       = 0;
        n_acc     = 0;
        n_done    = 0;
        reg_err   = 0;
        mem_err   = 0;
        exc_err   = 0;
        other_err = 0;

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // offered instruction holds until taken
        while (n_acc < n_inst) begin
            if (!in_valid || taken) begin
                if ($urandom % 5 != 0) begin
                    make_inst(in_inst);
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = ($urandom % 4) != 0;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;

        while (inst_q.size() != 0) begin
            out_ready = ($urandom % 4) != 0;
            @(posedge clk);
            #1;
        end

        if (n_done != n_inst) begin
            other_err++;
            $display("only %0d of %0d instructions produced a result", n_done, n_inst);
        end
        $display("checked %0d results: errors reg %0d, mem %0d, exception %0d, other %0d",
                 n_done, reg_err, mem_err, exc_err, other_err);
        if (reg_err + mem_err + exc_err + other_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/exe_pkg.sv
hw/exe_decode.sv
hw/exe_alu.sv
hw/exe_muldiv.sv
hw/exe_result.sv
hw/exe_stage.sv
bench/exe_stage_chk.sv
bench/exe_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module exe_stage_tb -o exe_stage_sim

status=0
./obj_dir/exe_stage_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
